// ==== Makefile ====
# Verilator build and run of the AHCI read DMA testbench
VERILATOR ?= verilator
TOP       ?= tb_ahci_dma
FILELIST  ?= ahci_dma.f
OBJ_DIR   ?= obj_dir
SEED_ARGS ?= +verilator+seed+1
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the simulation, fails unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SEED_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== ahci_dma.f ====
src/ahci_dma_pkg.sv
src/ahci_dma_rd_seq.sv
src/ahci_dma_ct_store.sv
src/ahci_dma_prd_decode.sv
src/ahci_dma_rd_fifo.sv
src/ahci_dma.sv
testbench/ahci_dma_props.sv
testbench/tb_ahci_dma.sv

// ==== src/ahci_dma.sv ====
//////////////////////////////
// AHCI command DMA, memory to device only
// one clock, one read burst outstanding at a time
// cmd_start ignored while cmd_busy
//////////////////////////////
`timescale 1ns/1ps

module ahci_dma
    import ahci_dma_pkg::*;
(
    input  logic               hclk,
    input  logic               hrst,          // sync, active high
    // command control
    input  logic               cmd_start,     // one-cycle pulse
    input  logic [addr_w-1:0]  ctba,          // command table base
    input  logic [prdtl_w-1:0] prdtl,         // PRD entry count
    output logic               cmd_busy,
    output logic               ct_busy,       // table fetch in progress
    output logic               cmd_done,
    output logic               prd_done,
    output logic               prd_irq,
    // command table readback
    input  logic               ct_re,
    input  logic [4:0]         ct_addr,       // dword address
    output logic [dword_w-1:0] ct_data,       // one cycle after ct_re
    // memory read address channel
    output logic               mem_ar_valid,
    input  logic               mem_ar_ready,
    output logic [addr_w-1:0]  mem_ar_addr,
    output logic [3:0]         mem_ar_len,    // beats minus one
    // memory read data channel
    input  logic [qword_w-1:0] mem_r_data,
    input  logic               mem_r_valid,
    input  logic               mem_r_last,
    output logic               mem_r_ready,
    // device stream
    output logic [dword_w-1:0] sys_out,
    output logic               sys_dav,
    input  logic               sys_re
);

    rd_kind_t           rd_kind;
    logic [3:0]         beat_idx;
    logic               beat_fire;
    logic [addr_w-1:0]  prd_addr;
    logic [dbc_w:0]     prd_dwords;
    logic               prd_irq_en;
    logic               prd_valid;
    logic               fifo_ready;
    logic               region_done;

    ahci_dma_rd_seq i_rd_seq (
        .hclk, .hrst, .cmd_start, .ctba, .prdtl,
        .mem_ar_ready, .mem_r_valid, .mem_r_last,
        .prd_addr, .prd_dwords, .prd_irq_en, .prd_valid,
        .fifo_ready, .region_done,
        .cmd_busy, .ct_busy, .cmd_done, .prd_done, .prd_irq,
        .mem_ar_valid, .mem_ar_addr, .mem_ar_len, .mem_r_ready,
        .rd_kind, .beat_idx, .beat_fire
    );

    ahci_dma_ct_store i_ct_store (
        .hclk, .hrst, .cmd_start, .rd_kind, .beat_idx, .beat_fire,
        .mem_r_data, .ct_re, .ct_addr, .ct_data
    );

    ahci_dma_prd_decode i_prd_decode (
        .hclk, .hrst, .rd_kind, .beat_idx, .beat_fire, .mem_r_data,
        .prd_addr, .prd_dwords, .prd_irq_en, .prd_valid
    );

    ahci_dma_rd_fifo i_rd_fifo (
        .hclk, .hrst, .rd_kind, .beat_fire, .mem_r_data,
        .prd_addr, .prd_dwords, .prd_valid, .sys_re,
        .fifo_ready, .region_done, .sys_out, .sys_dav
    );

endmodule

// ==== src/ahci_dma_ct_store.sv ====
//////////////////////////////
// command table store, 32 dwords
// filled from table beats, low dword at even address
// readback registered, valid one cycle after ct_re
//////////////////////////////
`timescale 1ns/1ps

module ahci_dma_ct_store
    import ahci_dma_pkg::*;
(
    input  logic                 hclk,
    input  logic                 hrst,
    input  logic                 cmd_start,
    input  rd_kind_t             rd_kind,
    input  logic [3:0]           beat_idx,
    input  logic                 beat_fire,
    input  logic [qword_w-1:0]   mem_r_data,
    input  logic                 ct_re,
    input  logic [4:0]           ct_addr,
    output logic [dword_w-1:0]   ct_data
);

    logic [dword_w-1:0] ct_ram [ct_dwords];
    logic               ct_we;

    assign ct_we = beat_fire && (rd_kind == rk_table); // ignore PRD and data beats

    always_ff @(posedge hclk) begin
        if (ct_we) begin
            ct_ram[{beat_idx, 1'b0}] <= mem_r_data[dword_w-1:0];        // low half
            ct_ram[{beat_idx, 1'b1}] <= mem_r_data[qword_w-1:dword_w];  // high half
        end
    end

    // readback register, cleared for a new command unless a read is due
    always_ff @(posedge hclk) begin
        if (hrst) begin
            ct_data <= '0;
        end else if (ct_re) begin
            ct_data <= ct_ram[ct_addr];
        end else if (cmd_start) begin
            ct_data <= '0;
        end
    end

endmodule

// ==== src/ahci_dma_pkg.sv ====
//////////////////////////////
// shared widths and table layout for the AHCI read DMA
// data addresses dword aligned, region lengths in whole dwords
// command table base must be 128-byte aligned
//////////////////////////////
package ahci_dma_pkg;

    // bus and stream widths
    localparam int addr_w  = 32;  // system address
    localparam int qword_w = 64;  // memory read data
    localparam int dword_w = 32;  // device side stream

    // command table and PRD table layout
    localparam int ct_dwords   = 32;   // dwords kept for readback
    localparam int ct_beats    = 16;   // 128 bytes as qwords
    localparam int prd_beats   = 2;    // one PRD entry
    localparam int prdt_offset = 128;  // PRD table follows the command FIS area
    localparam int prd_bytes   = 16;   // size of one entry

    // data bursts
    localparam int max_burst = 16;  // limited by 4-bit len

    // counters
    localparam int dbc_w   = 20;  // dword count field, minus one
    localparam int prdtl_w = 16;  // PRD entries per command

    // read FIFO
    localparam int fifo_depth = 8;                   // qword slots
    localparam int fifo_aw    = $clog2(fifo_depth);  // slot index bits

    // which burst owns the read data channel
    typedef enum logic [1:0] {
        rk_none,   // nothing outstanding
        rk_table,  // command table fetch
        rk_prd,    // one PRD entry
        rk_data    // data region burst
    } rd_kind_t;

endpackage

// ==== src/ahci_dma_prd_decode.sv ====
//////////////////////////////
// PRD entry decoder
// beat 0 low dword is the data address
// beat 1 high dword holds dbc and the interrupt bit
// outputs hold until the next entry is read
//////////////////////////////
`timescale 1ns/1ps

module ahci_dma_prd_decode
    import ahci_dma_pkg::*;
(
    input  logic               hclk,
    input  logic               hrst,
    input  rd_kind_t           rd_kind,
    input  logic [3:0]         beat_idx,
    input  logic               beat_fire,
    input  logic [qword_w-1:0] mem_r_data,
    output logic [addr_w-1:0]  prd_addr,
    output logic [dbc_w:0]     prd_dwords,   // dword count, one more than dbc
    output logic               prd_irq_en,
    output logic               prd_valid     // one cycle after beat 1
);

    logic              prd_fire;
    logic              beat0;
    logic              beat1;
    logic [dbc_w-1:0]  dbc;        // dwords minus one
    logic [dword_w-1:0] hi_dw;

    assign prd_fire = beat_fire && (rd_kind == rk_prd);
    assign beat0    = prd_fire && (beat_idx == 4'd0);
    assign beat1    = prd_fire && (beat_idx == 4'd1);
    assign hi_dw    = mem_r_data[qword_w-1:dword_w];
    assign dbc      = hi_dw[dbc_w+1:2];   // bits 21:2 of dword 3

    // entry fields
    always_ff @(posedge hclk) begin
        if (beat0) prd_addr <= mem_r_data[addr_w-1:0];
        if (beat1) begin
            prd_dwords <= (dbc_w+1)'(dbc) + 1'b1;
            prd_irq_en <= hi_dw[dword_w-1];      // bit 31, I flag
        end
    end

    always_ff @(posedge hclk) begin
        if (hrst) begin
            prd_valid <= 1'b0;
        end else begin
            prd_valid <= beat1;
        end
    end

endmodule

// ==== src/ahci_dma_rd_fifo.sv ====
//////////////////////////////
// qword read FIFO with dword output for the device
// a region starts at the dword picked by address bit 2
// unused upper half of the last qword is dropped
// ready drops below two free slots
//////////////////////////////
`timescale 1ns/1ps

module ahci_dma_rd_fifo
    import ahci_dma_pkg::*;
(
    input  logic               hclk,
    input  logic               hrst,
    input  rd_kind_t           rd_kind,
    input  logic               beat_fire,
    input  logic [qword_w-1:0] mem_r_data,
    input  logic [addr_w-1:0]  prd_addr,
    input  logic [dbc_w:0]     prd_dwords,
    input  logic               prd_valid,
    input  logic               sys_re,
    output logic               fifo_ready,
    output logic               region_done,
    output logic [dword_w-1:0] sys_out,
    output logic               sys_dav
);

    logic [qword_w-1:0] fifo_mem [fifo_depth];
    logic [fifo_aw:0]   wr_ptr;     // extra bit tells full from empty
    logic [fifo_aw:0]   rd_ptr;
    logic [fifo_aw:0]   used;
    logic               half;       // 1 = upper dword of head qword
    logic [dbc_w:0]     dw_left;    // dwords still owed to the device
    logic               push;
    logic               pop_dw;
    logic               pop_qw;
    logic               last_dw;
    logic [qword_w-1:0] head;

    assign push       = beat_fire && (rd_kind == rk_data);
    assign used       = wr_ptr - rd_ptr;
    assign fifo_ready = (used <= (fifo_aw+1)'(fifo_depth - 2));
    assign head       = fifo_mem[rd_ptr[fifo_aw-1:0]];
    assign sys_out    = half ? head[qword_w-1:dword_w] : head[dword_w-1:0];
    assign sys_dav    = (used != '0) && (dw_left != '0);
    assign pop_dw     = sys_dav && sys_re;
    assign last_dw    = (dw_left == (dbc_w+1)'(1));
    assign pop_qw     = pop_dw && (half || last_dw); // release slot after high half or region end

    always_ff @(posedge hclk) begin
        if (push) fifo_mem[wr_ptr[fifo_aw-1:0]] <= mem_r_data;
    end

    always_ff @(posedge hclk) begin
        if (hrst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            half        <= 1'b0;
            dw_left     <= '0;
            region_done <= 1'b0;
        end else begin
            region_done <= pop_dw && last_dw;     // one cycle after final dword
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop_qw) rd_ptr <= rd_ptr + 1'b1;
            if (prd_valid) begin
                dw_left <= prd_dwords;
                half    <= prd_addr[2];           // odd dword start
            end else if (pop_dw) begin
                dw_left <= dw_left - 1'b1;
                half    <= !half && !last_dw;
            end
        end
    end

endmodule

// ==== src/ahci_dma_rd_seq.sv ====
//////////////////////////////
// read burst sequencer: table, then PRD, then region data
// only one burst on the bus, next issued after its last beat
// data bursts are full 16 beats except the region tail
//////////////////////////////
`timescale 1ns/1ps

module ahci_dma_rd_seq
    import ahci_dma_pkg::*;
(
    input  logic               hclk,
    input  logic               hrst,
    input  logic               cmd_start,
    input  logic [addr_w-1:0]  ctba,
    input  logic [prdtl_w-1:0] prdtl,
    input  logic               mem_ar_ready,
    input  logic               mem_r_valid,
    input  logic               mem_r_last,
    input  logic [addr_w-1:0]  prd_addr,
    input  logic [dbc_w:0]     prd_dwords,
    input  logic               prd_irq_en,
    input  logic               prd_valid,
    input  logic               fifo_ready,
    input  logic               region_done,
    output logic               cmd_busy,
    output logic               ct_busy,
    output logic               cmd_done,
    output logic               prd_done,
    output logic               prd_irq,
    output logic               mem_ar_valid,
    output logic [addr_w-1:0]  mem_ar_addr,
    output logic [3:0]         mem_ar_len,
    output logic               mem_r_ready,
    output rd_kind_t           rd_kind,
    output logic [3:0]         beat_idx,
    output logic               beat_fire
);

    logic [addr_w-1:0]  tbl_ptr;       // next PRD entry address
    logic [prdtl_w-1:0] prds_left;
    logic               last_prd;      // current region is the final one
    logic [dbc_w:0]     qw_left;       // qwords of region not yet requested
    logic [addr_w-1:0]  data_addr;     // qword aligned
    logic               prd_go;        // first PRD request after table
    logic               ct_zero_done;  // empty PRD table case
    logic               issue_prd;
    logic               issue_data;
    logic               start_ok;
    logic [dbc_w:0]     burst_qw;
    logic [dbc_w+1:0]   qw_sum;

    assign start_ok   = cmd_start && !cmd_busy;
    assign issue_prd  = prd_go || (region_done && !last_prd);
    assign issue_data = (rd_kind == rk_none) && (qw_left != '0);
    assign burst_qw   = (qw_left > (dbc_w+1)'(max_burst)) ? (dbc_w+1)'(max_burst) : qw_left;
    // leading odd dword costs one more qword
    assign qw_sum     = (dbc_w+2)'(prd_dwords) + (dbc_w+2)'(prd_addr[2]) + (dbc_w+2)'(1);

    // table and PRD reads always sink, data only with FIFO room
    assign mem_r_ready = (rd_kind == rk_table) || (rd_kind == rk_prd) ||
                         ((rd_kind == rk_data) && fifo_ready);
    assign beat_fire   = mem_r_valid && mem_r_ready;

    assign prd_done = region_done;
    assign prd_irq  = region_done && prd_irq_en;
    assign cmd_done = ct_zero_done || (region_done && last_prd);

    always_ff @(posedge hclk) begin
        if (hrst) begin
            cmd_busy     <= 1'b0;
            ct_busy      <= 1'b0;
            ct_zero_done <= 1'b0;
            prd_go       <= 1'b0;
            mem_ar_valid <= 1'b0;
            rd_kind      <= rk_none;
            beat_idx     <= '0;
            prds_left    <= '0;
            last_prd     <= 1'b0;
            qw_left      <= '0;
        end else begin
            ct_zero_done <= 1'b0;
            prd_go       <= 1'b0;
            if (mem_ar_valid && mem_ar_ready) mem_ar_valid <= 1'b0; // request taken
            if (beat_fire) begin
                beat_idx <= mem_r_last ? 4'd0 : beat_idx + 4'd1;
                if (mem_r_last) rd_kind <= rk_none;                 // burst complete
            end
            if (start_ok) begin
                cmd_busy     <= 1'b1;
                ct_busy      <= 1'b1;
                prds_left    <= prdtl;
                mem_ar_valid <= 1'b1;
                rd_kind      <= rk_table;
            end else if (cmd_done) begin
                cmd_busy <= 1'b0;
            end
            if (beat_fire && mem_r_last && (rd_kind == rk_table)) begin
                ct_busy      <= 1'b0;
                prd_go       <= (prds_left != '0);
                ct_zero_done <= (prds_left == '0);
            end
            if (issue_prd) begin
                mem_ar_valid <= 1'b1;
                rd_kind      <= rk_prd;
                prds_left    <= prds_left - 1'b1;
                last_prd     <= (prds_left == prdtl_w'(1));
            end else if (issue_data) begin
                mem_ar_valid <= 1'b1;
                rd_kind      <= rk_data;
            end
            if (prd_valid) qw_left <= qw_sum[dbc_w+1:1];
            else if (issue_data) qw_left <= qw_left - burst_qw;
        end
    end

    // request fields, only change while no request is pending
    always_ff @(posedge hclk) begin
        if (start_ok) begin
            mem_ar_addr <= ctba;
            mem_ar_len  <= 4'(ct_beats - 1);
            tbl_ptr     <= ctba + addr_w'(prdt_offset);
        end else if (issue_prd) begin
            mem_ar_addr <= tbl_ptr;
            mem_ar_len  <= 4'(prd_beats - 1);
            tbl_ptr     <= tbl_ptr + addr_w'(prd_bytes);
        end else if (issue_data) begin
            mem_ar_addr <= data_addr;
            mem_ar_len  <= 4'(burst_qw - 1'b1);
            data_addr   <= data_addr + addr_w'(max_burst * qword_w / 8);
        end
        if (prd_valid) data_addr <= {prd_addr[addr_w-1:3], 3'b000}; // round down to qword
    end

endmodule

// ==== testbench/ahci_dma_props.sv ====
//////////////////////////////
// handshake properties, bound to the DMA top level
// checked only outside reset except the sys_dav one
//////////////////////////////
`timescale 1ns/1ps

module ahci_dma_props
    import ahci_dma_pkg::*;
(
    input logic              hclk,
    input logic              hrst,
    input logic              cmd_busy,
    input logic              cmd_done,
    input logic              mem_ar_valid,
    input logic              mem_ar_ready,
    input logic [addr_w-1:0] mem_ar_addr,
    input logic [3:0]        mem_ar_len,
    input logic              sys_dav
);

    // request and its fields hold until taken
    ar_hold: assert property (@(posedge hclk) disable iff (hrst)
        mem_ar_valid && !mem_ar_ready |=>
            mem_ar_valid && $stable(mem_ar_addr) && $stable(mem_ar_len))
        else $error("read request dropped or changed before ready");

    done_in_cmd: assert property (@(posedge hclk) disable iff (hrst)
        cmd_done |-> cmd_busy)
        else $error("cmd_done outside a command");

    dav_reset: assert property (@(posedge hclk) hrst |=> !sys_dav)  // nothing to hand out
        else $error("sys_dav high after reset");

endmodule

bind ahci_dma ahci_dma_props i_ahci_dma_props (
    .hclk         (hclk),
    .hrst         (hrst),
    .cmd_busy     (cmd_busy),
    .cmd_done     (cmd_done),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar_ready (mem_ar_ready),
    .mem_ar_addr  (mem_ar_addr),
    .mem_ar_len   (mem_ar_len),
    .sys_dav      (sys_dav)
);

// ==== testbench/tb_ahci_dma.sv ====
//////////////////////////////
// testbench for the AHCI read DMA
// sparse memory, tables written, data from an address fill
// random ready/valid gaps on memory and device side
//////////////////////////////
`timescale 1ns/1ps

module tb_ahci_dma
    import ahci_dma_pkg::*;
();

    localparam int          n_cmds    = 8;             // random back-to-back commands
    localparam int          max_wait  = 20000;         // cycles per wait
    localparam logic [31:0] tbl_base  = 32'h0010_0000;
    localparam logic [31:0] data_base = 32'h2000_0000; // never written, fill only

    logic               hclk;
    logic               hrst;
    logic               cmd_start;
    logic [addr_w-1:0]  ctba;
    logic [prdtl_w-1:0] prdtl;
    logic               cmd_busy;
    logic               ct_busy;
    logic               cmd_done;
    logic               prd_done;
    logic               prd_irq;
    logic               ct_re;
    logic [4:0]         ct_addr;
    logic [dword_w-1:0] ct_data;
    logic               mem_ar_valid;
    logic               mem_ar_ready;
    logic [addr_w-1:0]  mem_ar_addr;
    logic [3:0]         mem_ar_len;
    logic [qword_w-1:0] mem_r_data;
    logic               mem_r_valid;
    logic               mem_r_last;
    logic               mem_r_ready;
    logic [dword_w-1:0] sys_out;
    logic               sys_dav;
    logic               sys_re;

    logic [qword_w-1:0] mem [int unsigned];  // written qwords by qword address
    logic [dword_w-1:0] exp_q [$];           // expected device stream
    integer             seed;
    integer             mem_seed;
    integer             dev_seed;
    logic [addr_w-1:0]  rd_addr;             // burst position in memory model
    int                 rd_left;
    int                 errors;
    int                 n_pass;
    int                 n_fail;
    int                 n_cmd_done;
    int                 n_prd_done;
    int                 n_prd_irq;
    int                 n_dav;
    int                 n_cmds_run;
    string              test_name;

    ahci_dma i_ahci_dma (.*);

    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;
    end

    function automatic int unsigned pick_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [qword_w-1:0] read_qword(input logic [addr_w-1:0] a);
        logic [addr_w-1:0] qa;
        qa = {a[addr_w-1:3], 3'b000};
        if (mem.exists(qa[addr_w-1:3])) return mem[qa[addr_w-1:3]];
        return {qa ^ 32'h9e37_79b9, {qa[15:0], qa[31:16]} + 32'h7f4a_7c15}; // fill
    endfunction

    function automatic logic [dword_w-1:0] read_dword(input logic [addr_w-1:0] a);
        logic [qword_w-1:0] q;
        q = read_qword(a);
        return a[2] ? q[qword_w-1:dword_w] : q[dword_w-1:0];
    endfunction

    task automatic write_qword(input logic [addr_w-1:0] a, input logic [qword_w-1:0] q);
        mem[a[addr_w-1:3]] = q;
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
            errors = errors + 1;
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("%s: timed out waiting for %s", test_name, what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    // memory model, one burst at a time
    always @(posedge hclk) begin
        if (hrst) begin
            mem_ar_ready <= 1'b0;
            mem_r_valid  <= 1'b0;
            mem_r_last   <= 1'b0;
            mem_r_data   <= '0;
            rd_left = 0;
        end else begin
            if (mem_r_valid && mem_r_ready) begin  // beat taken
                rd_addr = rd_addr + 32'd8;
                rd_left = rd_left - 1;
            end
            if (mem_ar_valid && mem_ar_ready) begin
                rd_addr = mem_ar_addr;
                rd_left = int'(mem_ar_len) + 1;
            end
            mem_ar_ready <= ($random(mem_seed) & 3) != 0;
            if (!mem_r_valid || mem_r_ready) begin  // else beat holds
                if (rd_left != 0 && ($random(mem_seed) & 3) != 0) begin
                    mem_r_valid <= 1'b1;
                    mem_r_data  <= read_qword(rd_addr);
                    mem_r_last  <= (rd_left == 1);
                end else begin
                    mem_r_valid <= 1'b0;
                    mem_r_last  <= 1'b0;
                end
            end
        end
    end

    // device side, random sys_re, stream compare
    always @(posedge hclk) begin
        sys_re <= ($random(dev_seed) & 3) != 0;
        if (!hrst && sys_dav && sys_re) begin
            assert (exp_q.size() != 0) else begin
                $display("%s: device got dword %h with none expected", test_name, sys_out);
                errors = errors + 1;
            end
            if (exp_q.size() != 0) begin
                check_value("sys_out", exp_q[0], sys_out);
                void'(exp_q.pop_front());
            end
        end
    end

    // pulse counters
    always @(posedge hclk) begin
        if (hrst) begin
            n_cmd_done <= 0;
            n_prd_done <= 0;
            n_prd_irq  <= 0;
            n_dav      <= 0;
        end else begin
            if (cmd_done) n_cmd_done <= n_cmd_done + 1;
            if (prd_done) n_prd_done <= n_prd_done + 1;
            if (prd_irq) n_prd_irq <= n_prd_irq + 1;
            if (sys_dav) n_dav <= n_dav + 1;
        end
    end

    task automatic wait_table_fetch();
        int t;
        t = 0;
        @(posedge hclk);  // ct_busy visible from here
        check_value("cmd_busy after cmd_start", 1, cmd_busy);
        check_value("ct_busy after cmd_start", 1, ct_busy);
        while (ct_busy && t < max_wait) begin
            @(posedge hclk);
            t++;
        end
        if (t >= max_wait) stop_on_timeout("end of table fetch");
    endtask

    task automatic wait_command_done(input int snap);
        int t;
        t = 0;
        while (n_cmd_done == snap && t < max_wait) begin
            @(posedge hclk);
            t++;
        end
        if (t >= max_wait) stop_on_timeout("cmd_done");
    endtask

    task automatic run_command(input string name, input int n_prd);
        logic [addr_w-1:0]  base;
        logic [addr_w-1:0]  daddr;
        logic [qword_w-1:0] q;
        logic [dword_w-1:0] exp_ct [ct_dwords];
        logic               irq_bit;
        int                 len;
        int                 irqs;
        int                 err0;
        int                 snap_cmd;
        int                 snap_prd;
        int                 snap_irq;
        int                 snap_dav;
        test_name = name;
        err0      = errors;
        irqs      = 0;
        base      = tbl_base + (pick_below(256) << 10);  // room for table and PRDs
        for (int i = 0; i < ct_beats; i++) begin
            q = {$random(seed), $random(seed)};
            write_qword(base + 8 * i, q);
            exp_ct[2 * i]     = q[dword_w-1:0];
            exp_ct[2 * i + 1] = q[qword_w-1:dword_w];
        end
        for (int p = 0; p < n_prd; p++) begin
            len     = 1 + int'(pick_below(40));
            daddr   = data_base + (pick_below(65536) << 2);  // odd and even dword starts
            irq_bit = pick_below(2) != 0;
            irqs    = irqs + int'(irq_bit);
            write_qword(base + prdt_offset + prd_bytes * p, {$random(seed), daddr});
            q = {irq_bit, 9'd0, 20'(len - 1), 2'b00, 32'($random(seed))};
            write_qword(base + prdt_offset + prd_bytes * p + 8, q);
            for (int k = 0; k < len; k++) begin
                exp_q.push_back(read_dword(daddr + 4 * k));
            end
        end
        snap_cmd = n_cmd_done;
        snap_prd = n_prd_done;
        snap_irq = n_prd_irq;
        snap_dav = n_dav;
        cmd_start <= 1'b1;
        ctba      <= base;
        prdtl     <= prdtl_w'(n_prd);
        @(posedge hclk);
        cmd_start <= 1'b0;
        wait_table_fetch();
        for (int a = 0; a < ct_dwords; a++) begin  // readback while data flows
            ct_re   <= 1'b1;
            ct_addr <= 5'(a);
            @(posedge hclk);
            ct_re <= 1'b0;
            @(posedge hclk);
            check_value($sformatf("ct_data[%0d]", a), exp_ct[a], ct_data);
        end
        wait_command_done(snap_cmd);
        n_cmds_run++;
        check_value("cmd_busy after cmd_done", 0, cmd_busy);
        check_value("dwords not delivered", 0, exp_q.size());
        check_value("prd_done count", n_prd, n_prd_done - snap_prd);
        check_value("prd_irq count", irqs, n_prd_irq - snap_irq);
        check_value("cmd_done count", 1, n_cmd_done - snap_cmd);
        if (n_prd == 0) check_value("sys_dav cycles", 0, n_dav - snap_dav);
        if (errors == err0) begin
            n_pass++;
            $display("test %s (%0d PRDs): passed", name, n_prd);
        end else begin
            n_fail++;
            $display("test %s (%0d PRDs): failed, %0d errors", name, n_prd, errors - err0);
        end
    endtask

    initial begin
        seed       = 32'hbfb8_f3e4;
        mem_seed   = seed ^ 32'h0000_5a5a;  // own streams per process
        dev_seed   = seed ^ 32'h0000_a5a5;
        hrst       = 1'b1;
        cmd_start  = 1'b0;
        ctba       = '0;
        prdtl      = '0;
        ct_re      = 1'b0;
        ct_addr    = '0;
        mem_ar_ready = 1'b0;
        mem_r_data   = '0;
        mem_r_valid  = 1'b0;
        mem_r_last   = 1'b0;
        sys_re     = 1'b0;
        errors     = 0;
        n_pass     = 0;
        n_fail     = 0;
        n_cmds_run = 0;
        test_name  = "reset";
        repeat (8) @(posedge hclk);
        hrst <= 1'b0;
        @(posedge hclk);
        run_command("empty_prdt", 0);
        run_command("single_prd", 1);
        for (int c = 0; c < n_cmds; c++) begin
            run_command($sformatf("random_cmd_%0d", c), 1 + int'(pick_below(6)));
        end
        run_command("empty_after_data", 0);
        test_name = "idle";
        repeat (20) @(posedge hclk);  // no stray pulses afterwards
        check_value("total cmd_done", n_cmds_run, n_cmd_done);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 n_pass + n_fail, n_pass, n_fail, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule
